//--- bus_pkg.sv
// Data-bus word types and address map shared by the router, the top level and the testbench
`default_nettype none

package bus_pkg;

    localparam int BUS_W    = 32;
    localparam int OFFSET_W = 19;  // Byte offset inside a region in bits 18 down to 0

    typedef logic [BUS_W-1:0] bus_word_t;
    typedef logic [3:0]       bus_mask_t;

    // Target of a data access after decoding
    typedef enum logic [1:0] {
        REGION_MEM,
        REGION_TMR,
        REGION_NONE
    } region_e;

    // One address word that is seen either whole or split into its region flags
    typedef union packed {
        bus_word_t raw;
        struct packed {
            logic                        top;
            logic                        l1v;     // Bit 30 selects external memory
            logic                        per;     // Bit 29 was the peripheral bus
            logic                        tmr;     // Bit 28 selects the cycle timer
            logic [BUS_W-OFFSET_W-5:0]   spare;
            logic [OFFSET_W-1:0]         offset;
        } fields;
    } bus_addr_u;

endpackage

`default_nettype wire

//--- dbus_router.sv
// Decodes the core data address and steers each access to external memory, the timer or nowhere
`default_nettype none

module dbus_router #(
    parameter int MEM_ADDR_W = mem_pkg::MEM_ADDR_W_DEF
) (
    input  logic               dbus_sel_i,
    input  bus_pkg::bus_addr_u dbus_addr_i,
    input  bus_pkg::bus_word_t dbus_wdata_i,
    input  bus_pkg::bus_mask_t dbus_mask_i,
    output bus_pkg::bus_word_t dbus_rdata_o,
    output logic               dbus_stall_o,

    input  bus_pkg::bus_word_t tmr_count_i,

    iomem_if.requester         mem
);
    import bus_pkg::*;

    region_e region;

    // The L1V flag wins over TMR when both are set
    always_comb begin
        if (dbus_addr_i.fields.l1v) begin
            region = REGION_MEM;
        end else if (dbus_addr_i.fields.tmr) begin
            region = REGION_TMR;
        end else begin
            region = REGION_NONE;
        end
    end

    // Memory request fields are passed on unchanged and held by the core while it stalls
    assign mem.valid = dbus_sel_i && (region == REGION_MEM);
    assign mem.addr  = dbus_addr_i.raw[MEM_ADDR_W+1:2];  // Word address from the raw view
    assign mem.wdata = dbus_wdata_i;
    assign mem.wstrb = dbus_mask_i;  // Zero mask makes this a read

    always_comb begin
        case (region)
            REGION_MEM: begin
                dbus_rdata_o = mem.rdata;
                dbus_stall_o = dbus_sel_i && !mem.ready;
            end
            REGION_TMR: begin
                // Timer answers in the same cycle
                dbus_rdata_o = tmr_count_i;
                dbus_stall_o = 1'b0;
            end
            default: begin
                dbus_rdata_o = '0;  // Unmapped reads return zero
                dbus_stall_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- iomem_arbiter.sv
// Shares the external iomem port between the data side and instruction fetch, data first
`default_nettype none

module iomem_arbiter #(
    parameter int MEM_ADDR_W = mem_pkg::MEM_ADDR_W_DEF
) (
    input  logic                   clk_i,
    input  logic                   rst_i,

    iomem_if.responder             data,

    input  logic                   fetch_valid_i,
    input  logic [MEM_ADDR_W-1:0]  fetch_addr_i,
    output logic                   fetch_ready_o,
    output mem_pkg::mem_word_t     fetch_rdata_o,

    output logic                   iomem_valid_o,
    input  logic                   iomem_ready_i,
    output mem_pkg::mem_strb_t     iomem_wstrb_o,
    output bus_pkg::bus_word_t     iomem_addr_o,
    output mem_pkg::mem_word_t     iomem_wdata_o,
    input  mem_pkg::mem_word_t     iomem_rdata_i
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_DATA,
        GNT_FETCH
    } gnt_e;

    gnt_e                  gnt_q;
    logic [MEM_ADDR_W-1:0] word_addr;

    // A grant is taken only from idle and dropped after the ready cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_q <= GNT_IDLE;
        end else begin
            case (gnt_q)
                GNT_IDLE: begin
                    if (data.valid) begin
                        gnt_q <= GNT_DATA;
                    end else if (fetch_valid_i) begin
                        gnt_q <= GNT_FETCH;
                    end
                end
                GNT_DATA, GNT_FETCH: begin
                    if (iomem_ready_i) begin
                        gnt_q <= GNT_IDLE;
                    end
                end
                default: gnt_q <= GNT_IDLE;
            endcase
        end
    end

    always_comb begin
        iomem_valid_o = 1'b0;
        iomem_wstrb_o = '0;
        iomem_wdata_o = '0;
        word_addr     = '0;
        data.ready    = 1'b0;
        data.rdata    = '0;
        fetch_ready_o = 1'b0;
        fetch_rdata_o = '0;
        case (gnt_q)
            GNT_DATA: begin
                iomem_valid_o = 1'b1;
                iomem_wstrb_o = data.wstrb;
                iomem_wdata_o = data.wdata;
                word_addr     = data.addr;
                data.ready    = iomem_ready_i;
                data.rdata    = iomem_rdata_i;
            end
            GNT_FETCH: begin
                // Fetches only read, so the strobe stays zero
                iomem_valid_o = 1'b1;
                word_addr     = fetch_addr_i;
                fetch_ready_o = iomem_ready_i;
                fetch_rdata_o = iomem_rdata_i;
            end
            default: ;
        endcase
    end

    // Byte address with the low two bits and the bits above the word address zero
    assign iomem_addr_o = bus_word_t'({word_addr, 2'b00});

endmodule

`default_nettype wire

//--- iomem_if.sv
// One iomem request and its response, passed from the data router to the memory arbiter
`default_nettype none

interface iomem_if #(
    parameter int MEM_ADDR_W = mem_pkg::MEM_ADDR_W_DEF
);
    import mem_pkg::*;

    logic                  valid;
    logic                  ready;   // Transfer completes in the cycle this is high
    mem_strb_t             wstrb;
    logic [MEM_ADDR_W-1:0] addr;    // Word address
    mem_word_t             wdata;
    mem_word_t             rdata;

    modport requester (
        output valid, wstrb, addr, wdata,
        input  ready, rdata
    );

    modport responder (
        input  valid, wstrb, addr, wdata,
        output ready, rdata
    );

endinterface

`default_nettype wire

//--- list.f
bus_pkg.sv
mem_pkg.sv
iomem_if.sv
timer_unit.sv
dbus_router.sv
iomem_arbiter.sv
user_dbus.sv
tb_iomem_model.sv
tb_user_dbus.sv

//--- mem_pkg.sv
// External iomem word and strobe types plus the default word-address width of the memory port
`default_nettype none

package mem_pkg;

    // Word address covers byte address bits 18 down to 2
    localparam int MEM_ADDR_W_DEF = 17;

    typedef logic [31:0] mem_word_t;

    // A strobe of all zeros marks a read
    typedef logic [3:0]  mem_strb_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the user_dbus testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1

verilator --binary -f list.f --top-module tb_user_dbus -o sim_tb_user_dbus
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_user_dbus)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- tb_iomem_model.sv
// Testbench memory that answers iomem requests after a random number of wait cycles
`default_nettype none

module tb_iomem_model (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               valid_i,
    output logic               ready_o,
    input  mem_pkg::mem_strb_t wstrb_i,
    input  bus_pkg::bus_word_t addr_i,
    input  mem_pkg::mem_word_t wdata_i,
    output mem_pkg::mem_word_t rdata_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_pkg::*;

    mem_word_t  mem [256];
    integer     seed = 1142;
    integer     rnd;
    logic       busy_q;
    logic [1:0] wait_q;
    logic [7:0] idx;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA500_0000 ^ (i * 32'h0101_0101);  // Every word differs
        end
    end

    assign idx = addr_i[9:2];

    always @(posedge clk_i) begin
        ready_o <= 1'b0;
        if (rst_i) begin
            busy_q  <= 1'b0;
            wait_q  <= '0;
            rdata_o <= '0;
        end else if (valid_i && !ready_o) begin
            if (!busy_q) begin
                rnd = $random(seed);
                wait_q <= rnd[1:0];  // 0 to 3 extra wait cycles
                busy_q <= 1'b1;
            end else if (wait_q == 0) begin
                ready_o <= 1'b1;
                busy_q  <= 1'b0;
                rdata_o <= mem[idx];
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end else begin
                wait_q <= wait_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_user_dbus.sv
// Testbench top that runs directed tests on user_dbus against a behavioral iomem model
`default_nettype none

module tb_user_dbus;
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;
    import mem_pkg::*;

    localparam int AW = MEM_ADDR_W_DEF;
    localparam int MAX_CYCLES = 2000;  // About 60 transfers of 6 cycles with wide margin

    logic clk, rst, sel, stall, fvalid, fready, ivalid, iready;
    bus_word_t daddr, dwdata, drdata, iaddr;
    bus_mask_t dmask;
    logic [AW-1:0] faddr;
    mem_word_t frdata, iwdata, irdata;
    mem_strb_t iwstrb;
    bus_word_t addr_log[$];  // External addresses in completion order
    bus_word_t shadow[256];
    int errors = 0, tests_ok = 0, tests_bad = 0, cycles = 0, edges = 0;

    user_dbus #(.MEM_ADDR_W(AW)) dut0 (
        .clk_i(clk), .rst_i(rst),
        .dbus_sel_i(sel), .dbus_addr_i(daddr), .dbus_wdata_i(dwdata), .dbus_mask_i(dmask),
        .dbus_rdata_o(drdata), .dbus_stall_o(stall),
        .fetch_valid_i(fvalid), .fetch_addr_i(faddr), .fetch_ready_o(fready),
        .fetch_rdata_o(frdata),
        .iomem_valid_o(ivalid), .iomem_ready_i(iready), .iomem_wstrb_o(iwstrb),
        .iomem_addr_o(iaddr), .iomem_wdata_o(iwdata), .iomem_rdata_i(irdata)
    );

    tb_iomem_model mem0 (
        .clk_i(clk), .rst_i(rst), .valid_i(ivalid), .ready_o(iready), .wstrb_i(iwstrb),
        .addr_i(iaddr), .wdata_i(iwdata), .rdata_o(irdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Counts rising edges since reset was released as the expected timer value
    always @(posedge clk) begin
        cycles <= cycles + 1;
        edges  <= rst ? 0 : edges + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    always @(negedge clk) if (ivalid && iready) addr_log.push_back(iaddr);

    task automatic compare_word(input string name, input bus_word_t exp, input bus_word_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic data_access(input bus_word_t a, input bus_word_t wd, input bus_mask_t m,
                               output bus_word_t rd);
        @(posedge clk);
        sel    <= 1'b1;
        daddr  <= a;
        dwdata <= wd;
        dmask  <= m;
        do @(negedge clk); while (stall);
        rd = drdata;
        @(posedge clk);
        sel <= 1'b0;
    endtask

    task automatic fetch_read(input logic [AW-1:0] w, output mem_word_t rd);
        @(posedge clk);
        fvalid <= 1'b1;
        faddr  <= w;
        do @(negedge clk); while (!fready);
        rd = frdata;
        @(posedge clk);
        fvalid <= 1'b0;
    endtask

    function automatic bus_word_t merge_bytes(bus_word_t old, bus_word_t nw, bus_mask_t m);
        bus_word_t r;
        r = old;
        for (int b = 0; b < 4; b++) if (m[b]) r[8*b +: 8] = nw[8*b +: 8];
        return r;
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("PASS %s", name);
            tests_ok++;
        end else begin
            $display("FAIL %s", name);
            tests_bad++;
        end
    endtask

    task automatic mem_write_read();
        bus_word_t rd, a;
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = 32'h4000_0000 | (i * 36 + 16);
            shadow[i] = 32'h1234_0000 + i * 32'h0011_1111;
            data_access(a, shadow[i], 4'hF, rd);
            compare_word("iomem_addr_o", a & 32'h0007_FFFC, addr_log[$]);
        end
        for (int i = 0; i < 8; i++) begin
            data_access(32'h4000_0000 | (i * 36 + 16), '0, 4'h0, rd);
            compare_word("dbus_rdata_o", shadow[i], rd);
        end
        finish_test("memory write and read", e0);
    endtask

    task automatic byte_mask_write();
        bus_word_t rd, exp;
        int e0;
        e0 = errors;
        data_access(32'h4000_0200, 32'hCAFE_F00D, 4'hF, rd);
        data_access(32'h4000_0200, 32'h1122_3344, 4'b0101, rd);
        exp = merge_bytes(32'hCAFE_F00D, 32'h1122_3344, 4'b0101);
        data_access(32'h4000_0200, '0, 4'h0, rd);
        compare_word("dbus_rdata_o", exp, rd);
        finish_test("byte masks", e0);
    endtask

    task automatic timer_read();
        int e0;
        e0 = errors;
        repeat (2) begin
            @(posedge clk);
            sel    <= 1'b1;
            daddr  <= 32'h1000_0000;
            dmask  <= 4'hF;
            dwdata <= 32'hFFFF_0000;
            @(negedge clk);
            compare_bit("dbus_stall_o", 1'b0, stall);
            compare_word("dbus_rdata_o", bus_word_t'(edges), drdata);
            @(posedge clk);
            dmask <= 4'h0;  // Second access of the pair reads after the write
            @(negedge clk);
            compare_word("dbus_rdata_o", bus_word_t'(edges), drdata);
            @(posedge clk);
            sel <= 1'b0;
        end
        finish_test("timer", e0);
    endtask

    task automatic instruction_fetch();
        mem_word_t rd;
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            fetch_read(AW'((i * 36 + 16) >> 2), rd);
            compare_word("fetch_rdata_o", shadow[i], rd);
        end
        finish_test("fetch reads", e0);
    endtask

    task automatic arbiter_contention();
        bus_word_t drd;
        mem_word_t frd;
        int e0;
        e0 = errors;
        addr_log.delete();
        fork
            data_access(32'h4000_0034, '0, 4'h0, drd);
            fetch_read(AW'(16 >> 2), frd);
        join
        compare_word("dbus_rdata_o", shadow[1], drd);
        compare_word("fetch_rdata_o", shadow[0], frd);
        if (addr_log.size() != 2) begin
            $display("Contention produced %0d external transfers instead of 2", addr_log.size());
            errors++;
        end else begin
            compare_word("iomem_addr_o", 32'h0000_0034, addr_log[0]);  // Data side first
            compare_word("iomem_addr_o", 32'h0000_0010, addr_log[1]);
        end
        finish_test("contention", e0);
    endtask

    task automatic unmapped_access();
        int e0;
        e0 = errors;
        @(posedge clk);
        sel   <= 1'b1;
        daddr <= 32'h0000_0100;
        dmask <= 4'h0;
        repeat (2) begin
            @(negedge clk);
            compare_bit("dbus_stall_o", 1'b0, stall);
            compare_word("dbus_rdata_o", '0, drdata);
            compare_bit("iomem_valid_o", 1'b0, ivalid);
        end
        @(posedge clk);
        sel <= 1'b0;
        finish_test("unmapped region", e0);
    endtask

    initial begin
        rst    = 1'b1;
        sel    = 1'b0;
        daddr  = '0;
        dwdata = '0;
        dmask  = '0;
        fvalid = 1'b0;
        faddr  = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        mem_write_read();
        byte_mask_write();
        timer_read();
        instruction_fetch();
        arbiter_contention();
        unmapped_access();
        $display("Tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- timer_unit.sv
// Free-running cycle counter that the data bus reads through the TMR region
`default_nettype none

module timer_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    output bus_pkg::bus_word_t count_o
);
    import bus_pkg::*;

    bus_word_t count_q;

    // The counter is read-only so bus writes to this region have nowhere to land
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;  // Wraps after 2^32 cycles
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

//--- user_dbus.sv
// Memory-side bus top level joining the data router, the cycle timer and the iomem arbiter
`default_nettype none

module user_dbus #(
    parameter int MEM_ADDR_W = mem_pkg::MEM_ADDR_W_DEF
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  dbus_sel_i,
    input  bus_pkg::bus_word_t    dbus_addr_i,
    input  bus_pkg::bus_word_t    dbus_wdata_i,
    input  bus_pkg::bus_mask_t    dbus_mask_i,
    output bus_pkg::bus_word_t    dbus_rdata_o,
    output logic                  dbus_stall_o,

    input  logic                  fetch_valid_i,
    input  logic [MEM_ADDR_W-1:0] fetch_addr_i,
    output logic                  fetch_ready_o,
    output mem_pkg::mem_word_t    fetch_rdata_o,

    output logic                  iomem_valid_o,
    input  logic                  iomem_ready_i,
    output mem_pkg::mem_strb_t    iomem_wstrb_o,
    output bus_pkg::bus_word_t    iomem_addr_o,
    output mem_pkg::mem_word_t    iomem_wdata_o,
    input  mem_pkg::mem_word_t    iomem_rdata_i
);
    import bus_pkg::*;

    bus_word_t tmr_count;

    iomem_if #(.MEM_ADDR_W(MEM_ADDR_W)) dmem ();  // Data-side memory request

    timer_unit tmr0 (
        .clk_i   (clk_i    ),
        .rst_i   (rst_i    ),
        .count_o (tmr_count)
    );

    dbus_router #(.MEM_ADDR_W(MEM_ADDR_W)) rtr0 (
        .dbus_sel_i   (dbus_sel_i  ),
        .dbus_addr_i  (dbus_addr_i ),  // Word enters the union view here
        .dbus_wdata_i (dbus_wdata_i),
        .dbus_mask_i  (dbus_mask_i ),
        .dbus_rdata_o (dbus_rdata_o),
        .dbus_stall_o (dbus_stall_o),
        .tmr_count_i  (tmr_count   ),
        .mem          (dmem        )
    );

    iomem_arbiter #(.MEM_ADDR_W(MEM_ADDR_W)) arb0 (
        .clk_i         (clk_i        ),
        .rst_i         (rst_i        ),
        .data          (dmem         ),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i ),
        .fetch_ready_o (fetch_ready_o),
        .fetch_rdata_o (fetch_rdata_o),
        .iomem_valid_o (iomem_valid_o),
        .iomem_ready_i (iomem_ready_i),
        .iomem_wstrb_o (iomem_wstrb_o),
        .iomem_addr_o  (iomem_addr_o ),
        .iomem_wdata_o (iomem_wdata_o),
        .iomem_rdata_i (iomem_rdata_i)
    );

endmodule

`default_nettype wire
